// File: brch_params.svh
`ifndef BRCH_PARAMS_SVH
`define BRCH_PARAMS_SVH

// dispatch group shape
`define GRP_W      4     // slots per group
`define TRK_DEPTH  2     // unresolved branches we can hold

// word and pointer widths
`define INST_W     66    // raw instruction word
`define TAG_W      6     // branch tag, wraps
`define POS_W      7     // rob position, wraps

// opcode field, nonzero means branch
`define BRCH_LO    30
`define BRCH_HI    31

`endif

// File: brch_pkg.sv
`default_nettype none
`include "brch_params.svh"

package brch_pkg;

   typedef logic [`INST_W-1:0] inst_t;       // one instruction word
   typedef logic [`TAG_W-1:0]  brch_tag_t;   // branch tag
   typedef logic [`POS_W-1:0]  rob_pos_t;    // rob slot index
   typedef logic [`GRP_W-1:0]  slot_mask_t;  // one bit per slot

   // group offered by decode, every branch slot also has need set
   typedef struct packed {
      inst_t [`GRP_W-1:0] inst;
      slot_mask_t         need;    // slot takes a rob entry
   } group_t;

   typedef struct packed {
      brch_tag_t tag;
      rob_pos_t  pos;
   } trk_entry_t;                  // 13 bits per tracker entry

   typedef struct packed {
      logic      valid;            // one cycle pulse
      logic      mispredict;
      brch_tag_t tag;              // must be the oldest branch
   } resolve_t;

   typedef struct packed {
      logic       valid;
      rob_pos_t   first_pos;       // rob pos of first needing slot
      brch_tag_t  first_tag;       // tag of first branch
      slot_mask_t brch_mask;
   } disp_t;

   typedef enum logic {ACC_IDLE, ACC_HOLD} acc_state_t;

endpackage

`default_nettype wire

// File: group_accept.sv
`timescale 1ns/1ps
`default_nettype none
`include "brch_params.svh"

module group_accept import brch_pkg::*; (
   input  wire                clk,
   input  wire                rst_n,
   input  wire group_t        grp,
   input  wire                grp_req,
   output logic               grp_ack,
   input  wire [1:0]          free_cnt,    // tracker room left
   input  wire                flush_hit,
   output logic               take,        // group taken this cycle
   output slot_mask_t         brch_mask,
   output disp_t              disp,
   input  wire rob_pos_t      cur_pos,
   input  wire brch_tag_t     cur_tag
);
   acc_state_t state_q;
   logic [2:0] brch_cnt;      // branches in offered group
   logic       fits;          // tracker can hold them all
   logic       disp_vld_q;
   rob_pos_t   first_pos_q;
   brch_tag_t  first_tag_q;
   slot_mask_t mask_q;

   // opcode decode per slot
   always_comb
   begin
      brch_cnt = '0;
      for (int k = 0; k < `GRP_W; k++)
      begin
         brch_mask[k] = |grp.inst[k][`BRCH_HI:`BRCH_LO];
         brch_cnt     = brch_cnt + 3'(brch_mask[k]);
      end
   end

   assign fits    = brch_cnt <= {1'b0, free_cnt};
   assign take    = (state_q == ACC_IDLE) && grp_req && fits && !flush_hit;
   assign grp_ack = (state_q == ACC_HOLD);   // straight off the state flop

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= ACC_IDLE;
      else
      begin
         case (state_q)
            ACC_IDLE:
               if (take)
                  state_q <= ACC_HOLD;
            ACC_HOLD:
               if (!grp_req)
                  state_q <= ACC_IDLE;   // req seen low, ack drops next cycle
            default:
               state_q <= ACC_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         disp_vld_q <= 1'b0;
      else
         disp_vld_q <= take;         // one pulse per accepted group
   end

   // pointers sampled before they move on this edge
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         first_pos_q <= cur_pos;
         first_tag_q <= cur_tag;
         mask_q      <= brch_mask;
      end
   end

   assign disp = '{valid: disp_vld_q, first_pos: first_pos_q,
                   first_tag: first_tag_q, brch_mask: mask_q};

   // decode never offers more branches than the tracker could ever hold
   a_grp_brch_max: assert property (@(posedge clk) disable iff (!rst_n)
      grp_req |-> brch_cnt <= 3'(`TRK_DEPTH));

endmodule

`default_nettype wire

// File: rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none
`include "brch_params.svh"

module rob_alloc import brch_pkg::*; (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      take,
   input  wire slot_mask_t          need,
   input  wire                      flush_hit,
   input  wire rob_pos_t            flush_pos,   // first squashed pos
   output rob_pos_t                 cur_pos,     // rob tail
   output rob_pos_t [`GRP_W-1:0]    slot_pos
);
   localparam int CNT_W = $clog2(`GRP_W + 1);

   logic [CNT_W-1:0] need_run;   // need bits below slot k then the group total

   // prefix count of need bits
   always_comb
   begin
      need_run = '0;
      for (int k = 0; k < `GRP_W; k++)
      begin
         slot_pos[k] = cur_pos + rob_pos_t'(need_run);
         need_run    = need_run + CNT_W'(need[k]);
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cur_pos <= '0;
      else if (flush_hit)
         cur_pos <= flush_pos;                        // rewind past the branch
      else if (take)
         cur_pos <= cur_pos + rob_pos_t'(need_run);   // wraps at 128
   end

endmodule

`default_nettype wire

// File: brch_tag_alloc.sv
`timescale 1ns/1ps
`default_nettype none
`include "brch_params.svh"

module brch_tag_alloc import brch_pkg::*; (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      take,
   input  wire slot_mask_t          brch_mask,
   input  wire                      flush_hit,
   input  wire brch_tag_t           flush_tag,   // tag of mispredicted branch
   output brch_tag_t                cur_tag,     // next free tag
   output brch_tag_t [`GRP_W-1:0]   slot_tag
);
   localparam int CNT_W = $clog2(`GRP_W + 1);

   logic [CNT_W-1:0] brch_run;   // branches below slot k

   always_comb
   begin
      brch_run = '0;
      for (int k = 0; k < `GRP_W; k++)
      begin
         slot_tag[k] = cur_tag + brch_tag_t'(brch_run);   // only valid on branch slots
         brch_run    = brch_run + CNT_W'(brch_mask[k]);
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cur_tag <= '0;
      else if (flush_hit)
         cur_tag <= flush_tag + brch_tag_t'(1);       // resume after bad branch
      else if (take)
         cur_tag <= cur_tag + brch_tag_t'(brch_run);  // wraps at 64
   end

endmodule

`default_nettype wire

// File: brch_tracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "brch_params.svh"

module brch_tracker import brch_pkg::*; (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         take,
   input  wire slot_mask_t             brch_mask,
   input  wire rob_pos_t  [`GRP_W-1:0] slot_pos,
   input  wire brch_tag_t [`GRP_W-1:0] slot_tag,
   input  wire resolve_t               rsv,
   output logic [1:0]                  free_cnt,
   output logic                        flush_hit,   // internal rewind
   output logic                        flush,
   output rob_pos_t                    flush_pos,
   output brch_tag_t                   flush_tag,
   output logic                        squash       // front end sends no-ops
);
   localparam int PTR_W = $clog2(`TRK_DEPTH);

   trk_entry_t       ent_q [`TRK_DEPTH];   // oldest at head_q
   logic [PTR_W-1:0] head_q;
   logic [PTR_W-1:0] tail_q;
   logic [1:0]       cnt_q;                // live entries
   trk_entry_t       push_ent [2];         // first and second branch of group
   logic [1:0]       n_push;
   logic             pop;
   trk_entry_t       head_ent;

   // pick branch slots in slot order
   always_comb
   begin
      n_push      = '0;
      push_ent[0] = '0;
      push_ent[1] = '0;
      for (int k = 0; k < `GRP_W; k++)
      begin
         if (brch_mask[k])
         begin
            if (n_push == 2'd0)
               push_ent[0] = '{tag: slot_tag[k], pos: slot_pos[k]};
            else
               push_ent[1] = '{tag: slot_tag[k], pos: slot_pos[k]};
            n_push = n_push + 2'd1;
         end
      end
      if (!take)
         n_push = '0;   // mask is only meaningful on take
   end

   assign head_ent = ent_q[head_q];
   assign free_cnt = 2'(`TRK_DEPTH) - cnt_q;

   // resolves arrive in order so they always hit the head
   assign flush_hit = rsv.valid && rsv.mispredict;
   assign pop       = rsv.valid && !rsv.mispredict;
   assign flush     = flush_hit;
   assign squash    = flush_hit;
   assign flush_pos = flush_hit ? head_ent.pos + rob_pos_t'(1) : '0;   // squash from next pos
   assign flush_tag = flush_hit ? head_ent.tag : '0;

   // entry storage
   always_ff @(posedge clk)
   begin
      if (!flush_hit && n_push != 2'd0)
      begin
         ent_q[tail_q] <= push_ent[0];
         if (n_push == 2'd2)
            ent_q[tail_q + 1'b1] <= push_ent[1];   // second branch right behind
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head_q <= '0;
         tail_q <= '0;
         cnt_q  <= '0;
      end
      else if (flush_hit)
      begin
         head_q <= '0;   // everything younger is gone too
         tail_q <= '0;
         cnt_q  <= '0;
      end
      else
      begin
         tail_q <= tail_q + PTR_W'(n_push);
         if (pop)
            head_q <= head_q + 1'b1;
         cnt_q <= cnt_q + n_push - 2'(pop);   // push and pop may share a cycle
      end
   end

   // nothing to resolve in an empty tracker
   a_rsv_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
      rsv.valid |-> cnt_q != 2'd0);

   // backend resolves strictly oldest first
   a_rsv_in_order: assert property (@(posedge clk) disable iff (!rst_n)
      rsv.valid |-> rsv.tag == head_ent.tag);

endmodule

`default_nettype wire

// File: brch_dispatch.sv
`timescale 1ns/1ps
`default_nettype none
`include "brch_params.svh"

module brch_dispatch import brch_pkg::*; (
   input  wire                clk,
   input  wire                rst_n,
   input  wire group_t        grp,
   input  wire                grp_req,
   output logic               grp_ack,
   input  wire resolve_t      rsv,
   output disp_t              disp,
   output logic               flush,
   output rob_pos_t           flush_pos,
   output logic               squash
);
   logic                    take;         // group accept pulse
   slot_mask_t              brch_mask;
   logic [1:0]              free_cnt;
   logic                    flush_hit;
   brch_tag_t               flush_tag;
   rob_pos_t                cur_pos;
   brch_tag_t               cur_tag;
   rob_pos_t  [`GRP_W-1:0]  slot_pos;     // per-slot rob pos
   brch_tag_t [`GRP_W-1:0]  slot_tag;     // per-slot branch tag

   group_accept group_accept_i (
      .clk, .rst_n, .grp, .grp_req, .grp_ack, .free_cnt, .flush_hit,
      .take, .brch_mask, .disp, .cur_pos, .cur_tag
   );

   rob_alloc rob_alloc_i (
      .clk, .rst_n, .take, .need(grp.need), .flush_hit, .flush_pos,
      .cur_pos, .slot_pos
   );

   brch_tag_alloc brch_tag_alloc_i (
      .clk, .rst_n, .take, .brch_mask, .flush_hit, .flush_tag,
      .cur_tag, .slot_tag
   );

   brch_tracker brch_tracker_i (
      .clk, .rst_n, .take, .brch_mask, .slot_pos, .slot_tag, .rsv,
      .free_cnt, .flush_hit, .flush, .flush_pos, .flush_tag, .squash
   );

endmodule

`default_nettype wire

// File: tb_brch_dispatch.sv
`timescale 1ns/1ps
`default_nettype none
`include "brch_params.svh"

module tb_brch_dispatch import brch_pkg::*; ();
   localparam int N_GRP   = 400;   // enough to wrap pos and tag several times
   localparam int CLK_PER = 100;

   typedef enum {SRC_GAP, SRC_REQ, SRC_DROP} src_state_t;

   logic        clk;
   logic        rst_n;
   group_t      grp;
   logic        grp_req;
   logic        grp_ack;
   resolve_t    rsv;
   disp_t       disp;
   logic        flush;
   rob_pos_t    flush_pos;
   logic        squash;

   logic [31:0] rng_state;
   rob_pos_t    m_pos;          // model rob tail
   brch_tag_t   m_tag;          // model next tag
   trk_entry_t  m_q[$];         // model outstanding branches oldest first
   disp_t       exp_disp;       // expected disp for the coming cycle
   logic        exp_ack;
   int          groups_done;

   brch_dispatch brch_dispatch_i (
      .clk, .rst_n, .grp, .grp_req, .grp_ack, .rsv,
      .disp, .flush, .flush_pos, .squash
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PER / 2) clk = ~clk;
   end

   // xorshift32 over rng_state
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic int count_ones(input slot_mask_t m);
      int n;
      n = 0;
      for (int k = 0; k < `GRP_W; k++)
         n += int'(m[k]);
      return n;
   endfunction

   // nb_force below zero means random branch count
   task automatic build_group(input int nb_force, output group_t g, output slot_mask_t bm);
      int          nb;
      int          start;
      int          k;
      int          placed;
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      g.need = slot_mask_t'(next_rand());
      if (nb_force >= 0)
      begin
         g.need = '1;                                    // room for forced branches
         nb     = nb_force;
      end
      else
         nb = int'(next_rand() % 32'(((count_ones(g.need) < 2) ? count_ones(g.need) : 2) + 1));
      bm     = '0;
      start  = int'(next_rand() % 4);
      placed = 0;
      for (int i = 0; i < `GRP_W; i++)
      begin
         k = (start + i) % `GRP_W;
         if (g.need[k] && placed < nb)
         begin
            bm[k] = 1'b1;                               // branches only on needing slots
            placed++;
         end
      end
      for (int i = 0; i < `GRP_W; i++)
      begin
         r0 = next_rand();
         r1 = next_rand();
         r2 = next_rand();
         g.inst[i] = inst_t'({r2, r1, r0});
         if (bm[i])
            g.inst[i][`BRCH_HI:`BRCH_LO] = 2'(next_rand() % 3) + 2'd1;   // nonzero opcode
         else
            g.inst[i][`BRCH_HI:`BRCH_LO] = 2'd0;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_pos(input string name, input rob_pos_t exp, input rob_pos_t act);
      if (act !== exp)
      begin
         $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_disp(input string name, input disp_t exp, input disp_t act);
      if (act !== exp)
      begin
         $display("CHECK FAILED %s expected pos %0d tag %0d mask %b actual pos %0d tag %0d mask %b",
                  name, exp.first_pos, exp.first_tag, exp.brch_mask,
                  act.first_pos, act.first_tag, act.brch_mask);
         $display("TB FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic stop_on_error(input string what);
      $display("ERROR %s", what);
      $display("TB FAILED");
      $fatal(1, "%s", what);
   endtask

   // about 40 cycles per group is plenty even with back-pressure
   initial
   begin
      repeat (N_GRP * 40 + 20) @(posedge clk);
      $display("watchdog expired with %0d of %0d groups done", groups_done, N_GRP);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      src_state_t src;
      group_t     g;
      slot_mask_t bm;
      int         nb;
      int         gap;
      int         wait_cnt;
      int         need_below;
      int         brch_below;
      logic       take;
      logic       misp;
      logic       ack_prev;
      logic       nxt_req;
      group_t     nxt_grp;
      resolve_t   nxt_rsv;
      trk_entry_t ent;
      rst_n       <= 1'b0;
      grp         <= '0;
      grp_req     <= 1'b0;
      rsv         <= '0;
      rng_state   = 32'd74;
      m_pos       = '0;
      m_tag       = '0;
      exp_disp    = '0;
      exp_ack     = 1'b0;
      groups_done = 0;
      src         = SRC_GAP;
      g           = '0;
      bm          = '0;
      nb          = 0;
      gap         = 2;
      wait_cnt    = 0;
      ack_prev    = 1'b0;
      nxt_req     = 1'b0;
      nxt_grp     = '0;
      nxt_rsv     = '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_bit("reset grp_ack", 1'b0, grp_ack);
      check_bit("reset disp.valid", 1'b0, disp.valid);
      check_bit("reset flush", 1'b0, flush);
      check_bit("reset squash", 1'b0, squash);

      while (groups_done < N_GRP)
      begin
         @(posedge clk);
         grp_req <= nxt_req;
         grp     <= nxt_grp;
         rsv     <= nxt_rsv;
         @(negedge clk);

         // outputs of this cycle against the model
         misp = rsv.valid && rsv.mispredict;
         if (grp_ack && src == SRC_GAP)
            stop_on_error("grp_ack is high although no request was raised");
         check_bit("disp pulse on ack rise", grp_ack && !ack_prev, disp.valid);
         check_bit("grp_ack", exp_ack, grp_ack);
         check_bit("disp.valid", exp_disp.valid, disp.valid);
         if (exp_disp.valid)
            check_disp("disp record", exp_disp, disp);
         check_bit("flush", misp, flush);
         check_bit("squash", misp, squash);
         if (misp)
            check_pos("flush_pos", m_q[0].pos + rob_pos_t'(1), flush_pos);   // squash after branch
         ack_prev = grp_ack;

         // accept when idle with room for all branches and no flush
         take = grp_req && !exp_ack && (nb <= `TRK_DEPTH - m_q.size()) && !misp;

         // this edge applies resolve before push
         if (rsv.valid)
         begin
            if (rsv.mispredict)
            begin
               m_pos = m_q[0].pos + rob_pos_t'(1);
               m_tag = m_q[0].tag + brch_tag_t'(1);
               m_q.delete();                       // younger work is gone
            end
            else
               void'(m_q.pop_front());
         end
         exp_disp = '0;
         if (take)
         begin
            exp_disp   = '{valid: 1'b1, first_pos: m_pos, first_tag: m_tag, brch_mask: bm};
            need_below = 0;
            brch_below = 0;
            for (int k = 0; k < `GRP_W; k++)
            begin
               if (bm[k])
               begin
                  ent.tag = m_tag + brch_tag_t'(brch_below);
                  ent.pos = m_pos + rob_pos_t'(need_below);
                  m_q.push_back(ent);
                  brch_below++;
               end
               if (g.need[k])
                  need_below++;
            end
            m_pos = m_pos + rob_pos_t'(need_below);   // wraps at 128
            m_tag = m_tag + brch_tag_t'(brch_below);  // wraps at 64
         end
         exp_ack = exp_ack ? grp_req : take;           // hold until req seen low

         // four-phase source
         case (src)
            SRC_GAP:
               if (gap > 0)
                  gap--;
               else
               begin
                  // first two groups fill the tracker then wait on it
                  build_group((groups_done < 2) ? 2 - groups_done : -1, g, bm);
                  nb       = count_ones(bm);
                  nxt_grp  = g;
                  nxt_req  = 1'b1;
                  wait_cnt = 0;
                  src      = SRC_REQ;
               end
            SRC_REQ:
               if (grp_ack)
               begin
                  nxt_req = 1'b0;
                  src     = SRC_DROP;
               end
               else
                  wait_cnt++;
            SRC_DROP:
               if (!grp_ack)
               begin
                  groups_done++;
                  gap = int'(next_rand() % 4);
                  src = SRC_GAP;
               end
            default:
               stop_on_error("source state lost");
         endcase

         // resolve the oldest branch now and then
         nxt_rsv = '0;
         if (m_q.size() > 0)
         begin
            if (groups_done < 2)
            begin
               if (src == SRC_REQ && groups_done == 1 && wait_cnt == 4)
                  nxt_rsv = '{valid: 1'b1, mispredict: 1'b0, tag: m_q[0].tag};   // frees one
            end
            else if (next_rand() % 3 == 0)
               nxt_rsv = '{valid: 1'b1, mispredict: (next_rand() % 4 == 0), tag: m_q[0].tag};
         end
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
brch_pkg.sv
group_accept.sv
rob_alloc.sv
brch_tag_alloc.sv
brch_tracker.sv
brch_dispatch.sv
tb_brch_dispatch.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_brch_dispatch
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, scan $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "test: failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "test: no pass line in $(LOG)"; exit 1; fi
	@echo "test: ok"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
